/* design/backend_pkg.sv */
`default_nettype none

package backend_pkg;

    // datapath
    localparam int XLEN           = 32;

    // physical registers
    localparam int PREG_W         = 6;
    localparam int PREG_NUM       = 64;   // 1 << PREG_W

    // issue queues
    localparam int IQ_DEPTH       = 4;
    localparam int IQ_IDX_W       = 2;    // also wide enough for the age order
    localparam int FU_COUNT       = 2;    // alu queues feeding the bus

    // results waiting for the bus, per queue
    localparam int RES_FIFO_DEPTH = 2;

endpackage

`default_nettype wire

/* design/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    localparam int ALU_OP_W = 4;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7,   // signed compare
        ALU_LI  = 4'd8    // no sources, result is the immediate
    } alu_op_e;

endpackage

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import backend_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic [PREG_W-1:0] rd_src0_i,
    input  logic [PREG_W-1:0] rd_src1_i,
    output logic [XLEN-1:0]   rd_data0_o,
    output logic [XLEN-1:0]   rd_data1_o,
    output logic              rd_busy0_o,
    output logic              rd_busy1_o,
    input  logic              set_busy_i,
    input  logic [PREG_W-1:0] set_busy_preg_i,
    input  logic              cdb_valid_i,
    input  logic [PREG_W-1:0] cdb_preg_i,
    input  logic [XLEN-1:0]   cdb_data_i
);

    logic [XLEN-1:0]     data_q [PREG_NUM];
    logic [PREG_NUM-1:0] busy_q;   // result still outstanding

    assign rd_data0_o = data_q[rd_src0_i];
    assign rd_data1_o = data_q[rd_src1_i];
    assign rd_busy0_o = busy_q[rd_src0_i];
    assign rd_busy1_o = busy_q[rd_src1_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PREG_NUM; i++) begin
                data_q[i] <= '0;
            end
        end else if (cdb_valid_i) begin
            data_q[cdb_preg_i] <= cdb_data_i;   // writeback from the bus
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else if (flush_i) begin
            busy_q <= '0;
        end else begin
            if (cdb_valid_i) begin
                busy_q[cdb_preg_i] <= 1'b0;
            end
            // a new producer wins over a retiring one
            if (set_busy_i) begin
                busy_q[set_busy_preg_i] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch import backend_pkg::*, alu_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                dispatch_valid_i,
    output logic                dispatch_ready_o,
    input  alu_op_e             dispatch_op_i,
    input  logic [PREG_W-1:0]   dispatch_src0_i,
    input  logic [PREG_W-1:0]   dispatch_src1_i,
    input  logic [PREG_W-1:0]   dispatch_dst_i,
    input  logic [XLEN-1:0]     dispatch_imm_i,
    input  logic [XLEN-1:0]     rf_data0_i,
    input  logic [XLEN-1:0]     rf_data1_i,
    input  logic                rf_busy0_i,
    input  logic                rf_busy1_i,
    output logic                set_busy_o,
    output logic [PREG_W-1:0]   set_busy_preg_o,
    input  logic                cdb_valid_i,
    input  logic [PREG_W-1:0]   cdb_preg_i,
    input  logic [XLEN-1:0]     cdb_data_i,
    input  logic [FU_COUNT-1:0] iq_full_i,
    output logic [FU_COUNT-1:0] iq_wr_o,
    output alu_op_e             iq_op_o,
    output logic [PREG_W-1:0]   iq_dst_o,
    output logic [PREG_W-1:0]   iq_src0_o,
    output logic [PREG_W-1:0]   iq_src1_o,
    output logic [XLEN-1:0]     iq_val0_o,
    output logic [XLEN-1:0]     iq_val1_o,
    output logic                iq_rdy0_o,
    output logic                iq_rdy1_o
);

    logic last_q;   // queue that took the previous op
    logic pick;
    logic fire;

    // returns {ready, value}, a bus result in this cycle beats the register file
    function automatic logic [XLEN:0] source_value(
        input logic [PREG_W-1:0] src,
        input logic [XLEN-1:0]   rf_data,
        input logic              rf_busy
    );
        if (cdb_valid_i && cdb_preg_i == src) begin
            return {1'b1, cdb_data_i};
        end
        return {~rf_busy, rf_data};
    endfunction

    assign dispatch_ready_o = ~&iq_full_i;
    assign fire             = dispatch_valid_i & dispatch_ready_o;
    assign pick             = iq_full_i[~last_q] ? last_q : ~last_q;   // alternate unless full

    always_comb begin
        iq_wr_o       = '0;
        iq_wr_o[pick] = fire;
    end

    always_comb begin
        if (dispatch_op_i == ALU_LI) begin
            {iq_rdy0_o, iq_val0_o} = {1'b1, dispatch_imm_i};
            {iq_rdy1_o, iq_val1_o} = {1'b1, dispatch_imm_i};
        end else begin
            {iq_rdy0_o, iq_val0_o} = source_value(dispatch_src0_i, rf_data0_i, rf_busy0_i);
            {iq_rdy1_o, iq_val1_o} = source_value(dispatch_src1_i, rf_data1_i, rf_busy1_i);
        end
    end

    assign iq_op_o         = dispatch_op_i;
    assign iq_dst_o        = dispatch_dst_i;
    assign iq_src0_o       = dispatch_src0_i;
    assign iq_src1_o       = dispatch_src1_i;
    assign set_busy_o      = fire;
    assign set_busy_preg_o = dispatch_dst_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_q <= 1'b1;   // queue 0 first
        end else if (fire) begin
            last_q <= pick;
        end
    end

endmodule

`default_nettype wire

/* design/alu_iq.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_iq import backend_pkg::*, alu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              iq_wr_i,
    input  alu_op_e           iq_op_i,
    input  logic [PREG_W-1:0] iq_dst_i,
    input  logic [PREG_W-1:0] iq_src0_i,
    input  logic [PREG_W-1:0] iq_src1_i,
    input  logic [XLEN-1:0]   iq_val0_i,
    input  logic [XLEN-1:0]   iq_val1_i,
    input  logic              iq_rdy0_i,
    input  logic              iq_rdy1_i,
    output logic              full_o,
    input  logic              cdb_valid_i,
    input  logic [PREG_W-1:0] cdb_preg_i,
    input  logic [XLEN-1:0]   cdb_data_i,
    output logic              res_valid_o,
    input  logic              res_ready_i,
    output logic [PREG_W-1:0] res_preg_o,
    output logic [XLEN-1:0]   res_data_o
);

    logic [IQ_DEPTH-1:0] vld_q;
    logic [IQ_IDX_W-1:0] age_q  [IQ_DEPTH];   // 0 is the oldest
    alu_op_e             op_q   [IQ_DEPTH];
    logic [PREG_W-1:0]   dst_q  [IQ_DEPTH];
    logic [PREG_W-1:0]   src0_q [IQ_DEPTH];
    logic [PREG_W-1:0]   src1_q [IQ_DEPTH];
    logic [XLEN-1:0]     val0_q [IQ_DEPTH];
    logic [XLEN-1:0]     val1_q [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] rdy0_q;
    logic [IQ_DEPTH-1:0] rdy1_q;

    logic                sel_found;
    logic [IQ_IDX_W-1:0] sel_idx;
    logic [IQ_IDX_W-1:0] free_idx;
    logic [IQ_IDX_W:0]   occupied;
    logic [IQ_IDX_W-1:0] new_age;
    logic                issue_en;
    logic                issue;

    logic                ex_valid_q;
    logic [PREG_W-1:0]   ex_preg_q;
    logic [XLEN-1:0]     ex_data_q;

    function automatic logic [XLEN-1:0] alu_calc(
        input alu_op_e         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return XLEN'($signed(a) < $signed(b));
            default: return a;   // li, immediate sits in operand 0
        endcase
    endfunction

    // oldest ready entry, lowest free slot, occupancy
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        free_idx  = '0;
        occupied  = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!vld_q[i]) begin
                free_idx = IQ_IDX_W'(i);
            end
        end
        for (int i = 0; i < IQ_DEPTH; i++) begin
            occupied = occupied + {{IQ_IDX_W{1'b0}}, vld_q[i]};
            if (vld_q[i] && rdy0_q[i] && rdy1_q[i]
                    && (!sel_found || age_q[i] < age_q[sel_idx])) begin
                sel_found = 1'b1;
                sel_idx   = IQ_IDX_W'(i);
            end
        end
    end

    assign full_o   = &vld_q;
    assign issue_en = !ex_valid_q || res_ready_i;   // execute reg free or draining
    assign issue    = issue_en && sel_found;
    assign new_age  = IQ_IDX_W'(occupied - {{IQ_IDX_W{1'b0}}, issue});

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
            for (int i = 0; i < IQ_DEPTH; i++) begin
                age_q[i] <= '0;
            end
        end else if (flush_i) begin
            vld_q <= '0;
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (issue && sel_idx == IQ_IDX_W'(i)) begin
                    vld_q[i] <= 1'b0;
                end else if (issue && age_q[i] > age_q[sel_idx]) begin
                    age_q[i] <= age_q[i] - 1'b1;   // close the gap
                end
                if (iq_wr_i && free_idx == IQ_IDX_W'(i)) begin
                    vld_q[i] <= 1'b1;
                    age_q[i] <= new_age;    // youngest
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (iq_wr_i && free_idx == IQ_IDX_W'(i)) begin
                op_q[i]   <= iq_op_i;
                dst_q[i]  <= iq_dst_i;
                src0_q[i] <= iq_src0_i;
                src1_q[i] <= iq_src1_i;
                val0_q[i] <= iq_val0_i;
                val1_q[i] <= iq_val1_i;
                rdy0_q[i] <= iq_rdy0_i;
                rdy1_q[i] <= iq_rdy1_i;
            end else begin
                // wakeup
                if (cdb_valid_i && !rdy0_q[i] && src0_q[i] == cdb_preg_i) begin
                    rdy0_q[i] <= 1'b1;
                    val0_q[i] <= cdb_data_i;
                end
                if (cdb_valid_i && !rdy1_q[i] && src1_q[i] == cdb_preg_i) begin
                    rdy1_q[i] <= 1'b1;
                    val1_q[i] <= cdb_data_i;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_q <= 1'b0;
        end else if (flush_i) begin
            ex_valid_q <= 1'b0;
        end else if (issue_en) begin
            ex_valid_q <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ex_preg_q <= dst_q[sel_idx];
            ex_data_q <= alu_calc(op_q[sel_idx], val0_q[sel_idx], val1_q[sel_idx]);
        end
    end

    assign res_valid_o = ex_valid_q;
    assign res_preg_o  = ex_preg_q;
    assign res_data_o  = ex_data_q;

endmodule

`default_nettype wire

/* design/result_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module result_fifo import backend_pkg::*; #(
    parameter int DEPTH = RES_FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [PREG_W-1:0] in_preg_i,
    input  logic [XLEN-1:0]   in_data_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output logic [PREG_W-1:0] out_preg_o,
    output logic [XLEN-1:0]   out_data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [PREG_W-1:0] preg_mem [DEPTH];
    logic [XLEN-1:0]   data_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [PTR_W:0]    count_q;
    logic              push;
    logic              pop;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready_o  = (count_q < DEPTH);
    assign out_valid_o = (count_q != '0);   // no bypass from the input
    assign push        = in_valid_i & in_ready_o;
    assign pop         = out_valid_o & out_ready_i;
    assign out_preg_o  = preg_mem[rd_ptr_q];
    assign out_data_o  = data_mem[rd_ptr_q];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            preg_mem[wr_ptr_q] <= in_preg_i;
            data_mem[wr_ptr_q] <= in_data_i;
        end
    end

endmodule

`default_nettype wire

/* design/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter import backend_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [FU_COUNT-1:0]             fifo_valid_i,
    output logic [FU_COUNT-1:0]             fifo_ready_o,
    input  logic [FU_COUNT-1:0][PREG_W-1:0] fifo_preg_i,
    input  logic [FU_COUNT-1:0][XLEN-1:0]   fifo_data_i,
    output logic                            cdb_valid_o,
    output logic [PREG_W-1:0]               cdb_preg_o,
    output logic [XLEN-1:0]                 cdb_data_o
);

    logic last_q;   // fifo granted most recently
    logic gnt;

    // the other fifo gets first try
    assign gnt         = fifo_valid_i[~last_q] ? ~last_q : last_q;
    assign cdb_valid_o = |fifo_valid_i;
    assign cdb_preg_o  = fifo_preg_i[gnt];
    assign cdb_data_o  = fifo_data_i[gnt];

    always_comb begin
        fifo_ready_o      = '0;
        fifo_ready_o[gnt] = cdb_valid_o;   // one pop per cycle
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_q <= 1'b1;
        end else if (cdb_valid_o) begin
            last_q <= gnt;
        end
    end

endmodule

`default_nettype wire

/* design/alu_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_backend import backend_pkg::*, alu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              dispatch_valid_i,
    output logic              dispatch_ready_o,
    input  alu_op_e           dispatch_op_i,
    input  logic [PREG_W-1:0] dispatch_src0_i,
    input  logic [PREG_W-1:0] dispatch_src1_i,
    input  logic [PREG_W-1:0] dispatch_dst_i,
    input  logic [XLEN-1:0]   dispatch_imm_i,
    output logic              cdb_valid_o,
    output logic [PREG_W-1:0] cdb_preg_o,
    output logic [XLEN-1:0]   cdb_data_o
);

    logic [XLEN-1:0]                 rf_data0;
    logic [XLEN-1:0]                 rf_data1;
    logic                            rf_busy0;
    logic                            rf_busy1;
    logic                            set_busy;
    logic [PREG_W-1:0]               set_busy_preg;

    // shared queue payload, one write strobe per queue
    logic [FU_COUNT-1:0]             iq_wr;
    logic [FU_COUNT-1:0]             iq_full;
    alu_op_e                         iq_op;
    logic [PREG_W-1:0]               iq_dst;
    logic [PREG_W-1:0]               iq_src0;
    logic [PREG_W-1:0]               iq_src1;
    logic [XLEN-1:0]                 iq_val0;
    logic [XLEN-1:0]                 iq_val1;
    logic                            iq_rdy0;
    logic                            iq_rdy1;

    // execute reg -> fifo -> arbiter
    logic [FU_COUNT-1:0]             ex_valid;
    logic [FU_COUNT-1:0]             ex_ready;
    logic [FU_COUNT-1:0][PREG_W-1:0] ex_preg;
    logic [FU_COUNT-1:0][XLEN-1:0]   ex_data;
    logic [FU_COUNT-1:0]             fifo_valid;
    logic [FU_COUNT-1:0]             fifo_ready;
    logic [FU_COUNT-1:0][PREG_W-1:0] fifo_preg;
    logic [FU_COUNT-1:0][XLEN-1:0]   fifo_data;

    logic                            cdb_valid;
    logic [PREG_W-1:0]               cdb_preg;
    logic [XLEN-1:0]                 cdb_data;

    reg_file u_reg_file (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .rd_src0_i      (dispatch_src0_i),
        .rd_src1_i      (dispatch_src1_i),
        .rd_data0_o     (rf_data0),
        .rd_data1_o     (rf_data1),
        .rd_busy0_o     (rf_busy0),
        .rd_busy1_o     (rf_busy1),
        .set_busy_i     (set_busy),
        .set_busy_preg_i(set_busy_preg),
        .cdb_valid_i    (cdb_valid),
        .cdb_preg_i     (cdb_preg),
        .cdb_data_i     (cdb_data)
    );

    dispatch u_dispatch (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .dispatch_valid_i(dispatch_valid_i),
        .dispatch_ready_o(dispatch_ready_o),
        .dispatch_op_i   (dispatch_op_i),
        .dispatch_src0_i (dispatch_src0_i),
        .dispatch_src1_i (dispatch_src1_i),
        .dispatch_dst_i  (dispatch_dst_i),
        .dispatch_imm_i  (dispatch_imm_i),
        .rf_data0_i      (rf_data0),
        .rf_data1_i      (rf_data1),
        .rf_busy0_i      (rf_busy0),
        .rf_busy1_i      (rf_busy1),
        .set_busy_o      (set_busy),
        .set_busy_preg_o (set_busy_preg),
        .cdb_valid_i     (cdb_valid),
        .cdb_preg_i      (cdb_preg),
        .cdb_data_i      (cdb_data),
        .iq_full_i       (iq_full),
        .iq_wr_o         (iq_wr),
        .iq_op_o         (iq_op),
        .iq_dst_o        (iq_dst),
        .iq_src0_o       (iq_src0),
        .iq_src1_o       (iq_src1),
        .iq_val0_o       (iq_val0),
        .iq_val1_o       (iq_val1),
        .iq_rdy0_o       (iq_rdy0),
        .iq_rdy1_o       (iq_rdy1)
    );

    for (genvar k = 0; k < FU_COUNT; k++) begin : g_alu
        alu_iq u_alu_iq (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .flush_i    (flush_i),
            .iq_wr_i    (iq_wr[k]),
            .iq_op_i    (iq_op),
            .iq_dst_i   (iq_dst),
            .iq_src0_i  (iq_src0),
            .iq_src1_i  (iq_src1),
            .iq_val0_i  (iq_val0),
            .iq_val1_i  (iq_val1),
            .iq_rdy0_i  (iq_rdy0),
            .iq_rdy1_i  (iq_rdy1),
            .full_o     (iq_full[k]),
            .cdb_valid_i(cdb_valid),
            .cdb_preg_i (cdb_preg),
            .cdb_data_i (cdb_data),
            .res_valid_o(ex_valid[k]),
            .res_ready_i(ex_ready[k]),
            .res_preg_o (ex_preg[k]),
            .res_data_o (ex_data[k])
        );

        result_fifo #(
            .DEPTH(RES_FIFO_DEPTH)
        ) u_result_fifo (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .flush_i    (flush_i),
            .in_valid_i (ex_valid[k]),
            .in_ready_o (ex_ready[k]),
            .in_preg_i  (ex_preg[k]),
            .in_data_i  (ex_data[k]),
            .out_valid_o(fifo_valid[k]),
            .out_ready_i(fifo_ready[k]),
            .out_preg_o (fifo_preg[k]),
            .out_data_o (fifo_data[k])
        );
    end

    cdb_arbiter u_cdb_arbiter (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .fifo_valid_i(fifo_valid),
        .fifo_ready_o(fifo_ready),
        .fifo_preg_i (fifo_preg),
        .fifo_data_i (fifo_data),
        .cdb_valid_o (cdb_valid),
        .cdb_preg_o  (cdb_preg),
        .cdb_data_o  (cdb_data)
    );

    assign cdb_valid_o = cdb_valid;
    assign cdb_preg_o  = cdb_preg;
    assign cdb_data_o  = cdb_data;

endmodule

`default_nettype wire

/* sim/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;   // release away from the rising edge
    end

endmodule

`default_nettype wire

/* sim/tb_alu_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_alu_backend import backend_pkg::*, alu_pkg::*; ();

    localparam int WAIT_LIMIT = 200;   // cycles allowed per wait

    logic              clk;
    logic              rst_n;
    logic              flush_i;
    logic              dispatch_valid_i;
    logic              dispatch_ready_o;
    alu_op_e           dispatch_op_i;
    logic [PREG_W-1:0] dispatch_src0_i;
    logic [PREG_W-1:0] dispatch_src1_i;
    logic [PREG_W-1:0] dispatch_dst_i;
    logic [XLEN-1:0]   dispatch_imm_i;
    logic              cdb_valid_o;
    logic [PREG_W-1:0] cdb_preg_o;
    logic [XLEN-1:0]   cdb_data_o;

    // reference model
    logic [XLEN-1:0]     model_q  [PREG_NUM];   // values in program order
    logic [XLEN-1:0]     rf_q     [PREG_NUM];   // last value seen on the bus
    logic [XLEN-1:0]     expect_q [PREG_NUM];
    logic [PREG_NUM-1:0] pending_q;             // results still owed by the DUT

    string test_name;
    int    tests;
    int    failed;
    int    checks;
    int    errors;
    int    test_errors;
    logic  saw_stall;

    clk_gen #(
        .PERIOD    (40),
        .RST_CYCLES(5)
    ) u_clk_gen (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    alu_backend DUT (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .flush_i         (flush_i),
        .dispatch_valid_i(dispatch_valid_i),
        .dispatch_ready_o(dispatch_ready_o),
        .dispatch_op_i   (dispatch_op_i),
        .dispatch_src0_i (dispatch_src0_i),
        .dispatch_src1_i (dispatch_src1_i),
        .dispatch_dst_i  (dispatch_dst_i),
        .dispatch_imm_i  (dispatch_imm_i),
        .cdb_valid_o     (cdb_valid_o),
        .cdb_preg_o      (cdb_preg_o),
        .cdb_data_o      (cdb_data_o)
    );

    function automatic logic [XLEN-1:0] ref_result(
        input alu_op_e         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b,
        input logic [XLEN-1:0] imm
    );
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        sa = a;
        sb = b;
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return {{(XLEN - 1){1'b0}}, sa < sb};
            ALU_LI:  return imm;
            default: return '0;
        endcase
    endfunction

    // random register with no result outstanding and none on the bus
    function automatic logic [PREG_W-1:0] free_reg(input logic [PREG_NUM-1:0] avoid);
        int                start;
        logic [PREG_W-1:0] r;
        start = $urandom_range(0, PREG_NUM - 1);
        for (int i = 0; i < PREG_NUM; i++) begin
            r = PREG_W'(start + i);
            if (!pending_q[r] && !avoid[r] && !(cdb_valid_o && cdb_preg_o == r)) begin
                return r;
            end
        end
        errors++;
        $display("no free destination register in test %s", test_name);
        return '0;
    endfunction

    task automatic timed_out(input string what);
        $display("timeout: %s in test %s", what, test_name);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic check_value(
        input string           what,
        input logic [XLEN-1:0] expected,
        input logic [XLEN-1:0] actual
    );
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("CHECK FAILED %s %s: expected %08h, actual %08h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errors) begin
            $display("test %s: pass", test_name);
        end else begin
            failed++;
            $display("test %s: fail, %0d errors", test_name, errors - test_errors);
        end
    endtask

    // starts and ends on a falling edge
    task automatic send(
        input alu_op_e           op,
        input logic [PREG_W-1:0] src0,
        input logic [PREG_W-1:0] src1,
        input logic [PREG_W-1:0] dst,
        input logic [XLEN-1:0]   imm
    );
        int              waited;
        logic [XLEN-1:0] value;
        waited           = 0;
        dispatch_valid_i = 1'b1;
        dispatch_op_i    = op;
        dispatch_src0_i  = src0;
        dispatch_src1_i  = src1;
        dispatch_dst_i   = dst;
        dispatch_imm_i   = imm;
        while (!dispatch_ready_o) begin
            saw_stall = 1'b1;
            waited++;
            if (waited > WAIT_LIMIT) timed_out("dispatch_ready_o stayed low");
            @(negedge clk);
        end
        // accepted on the coming rising edge
        value          = ref_result(op, model_q[src0], model_q[src1], imm);
        model_q[dst]   = value;
        expect_q[dst]  = value;
        pending_q[dst] = 1'b1;
        @(negedge clk);
        dispatch_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ($countones(pending_q) != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) timed_out("results missing from the bus");
            @(negedge clk);
        end
    endtask

    // bus monitor
    always @(negedge clk) begin
        if (!rst_n) begin
            checks++;
            assert (!cdb_valid_o) else begin
                errors++;
                $display("cdb_valid_o was high during reset");
            end
        end else if (cdb_valid_o) begin
            checks++;
            assert (pending_q[cdb_preg_o]) else begin
                errors++;
                $display("unexpected bus result for preg %0d in test %s", cdb_preg_o, test_name);
            end
            if (pending_q[cdb_preg_o]) begin
                check_value($sformatf("preg %0d", cdb_preg_o), expect_q[cdb_preg_o], cdb_data_o);
                pending_q[cdb_preg_o] = 1'b0;
            end
            rf_q[cdb_preg_o] = cdb_data_o;
        end
    end

    initial begin
        logic [PREG_W-1:0]   ra;
        logic [PREG_W-1:0]   rb;
        logic [PREG_W-1:0]   rd;
        logic [PREG_NUM-1:0] lost;
        alu_op_e             op_sel;
        int                  waited;

        void'($urandom(69));
        flush_i          = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_op_i    = ALU_ADD;
        dispatch_src0_i  = '0;
        dispatch_src1_i  = '0;
        dispatch_dst_i   = '0;
        dispatch_imm_i   = '0;
        pending_q        = '0;
        saw_stall        = 1'b0;
        tests            = 0;
        failed           = 0;
        checks           = 0;
        errors           = 0;
        test_errors      = 0;
        test_name        = "reset";
        for (int i = 0; i < PREG_NUM; i++) begin
            model_q[i]  = '0;
            rf_q[i]     = '0;
            expect_q[i] = '0;
        end

        waited = 0;
        while (!rst_n) begin
            waited++;
            if (waited > WAIT_LIMIT) timed_out("reset never released");
            @(negedge clk);
        end
        @(negedge clk);

        start_test("reset_state");
        check_value("cdb_valid_o", '0, XLEN'(cdb_valid_o));
        check_value("dispatch_ready_o", XLEN'(1), XLEN'(dispatch_ready_o));
        end_test();

        start_test("opcodes");
        ra = free_reg('0);
        send(ALU_LI, '0, '0, ra, $urandom());
        rb = free_reg('0);
        send(ALU_LI, '0, '0, rb, $urandom());
        op_sel = op_sel.first();
        do begin
            if (op_sel != ALU_LI) send(op_sel, ra, rb, free_reg('0), '0);
            op_sel = op_sel.next();
        end while (op_sel != op_sel.first());
        send(ALU_SLT, rb, ra, free_reg('0), '0);   // other operand order
        wait_drain();
        end_test();

        start_test("dependent_chain");
        ra = free_reg('0);
        send(ALU_LI, '0, '0, ra, $urandom());
        rb = free_reg('0);
        send(ALU_LI, '0, '0, rb, $urandom());
        for (int i = 0; i < 8; i++) begin
            rd = free_reg('0);
            send(ALU_ADD, ra, rb, rd, '0);
            ra = rd;
        end
        wait_drain();
        end_test();

        start_test("back_pressure");
        saw_stall = 1'b0;
        ra = free_reg('0);
        send(ALU_LI, '0, '0, ra, $urandom());
        for (int i = 0; i < 6; i++) begin   // slow chain delays the last source
            rd = free_reg('0);
            send(ALU_ADD, ra, ra, rd, '0);
            ra = rd;
        end
        for (int i = 0; i < 12; i++) begin
            send(ALU_OR, ra, PREG_W'($urandom_range(0, PREG_NUM - 1)), free_reg('0), '0);
        end
        checks++;
        assert (saw_stall) else begin
            errors++;
            $display("dispatch_ready_o never went low in test %s", test_name);
        end
        wait_drain();
        end_test();

        start_test("random_stream");
        for (int i = 0; i < 200; i++) begin
            op_sel = op_sel.first();
            repeat ($urandom_range(0, op_sel.num() - 1)) op_sel = op_sel.next();
            send(op_sel, PREG_W'($urandom_range(0, PREG_NUM - 1)),
                 PREG_W'($urandom_range(0, PREG_NUM - 1)), free_reg('0), $urandom());
        end
        wait_drain();
        end_test();

        start_test("flush");
        ra = free_reg('0);
        send(ALU_LI, '0, '0, ra, $urandom());
        for (int i = 0; i < 6; i++) begin
            rd = free_reg('0);
            send(ALU_ADD, ra, ra, rd, '0);
            ra = rd;
        end
        flush_i = 1'b1;
        @(negedge clk);
        flush_i   = 1'b0;
        lost      = pending_q;
        pending_q = '0;
        model_q   = rf_q;   // lost results never reached the register file
        checks++;
        assert (lost != '0) else begin
            errors++;
            $display("nothing was in flight when flush_i was raised");
        end
        repeat (10) @(negedge clk);   // monitor catches any stale broadcast
        for (int r = 0; r < PREG_NUM; r++) begin
            if (lost[r]) begin
                send(ALU_OR, PREG_W'(r), PREG_W'(r), free_reg(lost), '0);
            end
        end
        wait_drain();
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
design/backend_pkg.sv
design/alu_pkg.sv
design/reg_file.sv
design/dispatch.sv
design/alu_iq.sv
design/result_fifo.sv
design/cdb_arbiter.sv
design/alu_backend.sv
sim/clk_gen.sv
sim/tb_alu_backend.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_alu_backend -Mdir obj_dir -o tb_alu_backend

./obj_dir/tb_alu_backend | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation finished without failures"
